//--- dv/spi_frame_engine_assertions.sv
`timescale 1ns/1ps

module spi_frame_engine_assertions (
    input logic clk,
    input logic arst_n,
    input logic sclk,
    input logic mosi,
    input logic cs_n
);
    int fail_count = 0;

    // SCLK idles low whenever the chip is deselected
    sclk_low_when_idle: assert property (@(posedge clk) disable iff (!arst_n) cs_n |-> !sclk)
    else begin
        $error("sclk is high while cs_n is high");
        fail_count++;
    end

    // Mode 0, the slave samples MOSI while SCLK is high
    mosi_stable_high: assert property (@(posedge clk) disable iff (!arst_n) sclk |-> $stable(mosi))
    else begin
        $error("mosi changed while sclk is high");
        fail_count++;
    end

    cs_high_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> cs_n)
    else begin
        $error("cs_n is low in the cycle after reset release");
        fail_count++;
    end

endmodule

//--- dv/tb_w5500_udp_tx.sv
`timescale 1ns/1ps

module tb_w5500_udp_tx;
    import w5500_regs_pkg::*;
    import link_cfg_pkg::*;

    localparam int ROWS               = 5;
    localparam int INIT_FRAMES        = 31;
    localparam int STATUS_POLLS       = 4;
    localparam int INIT_TIMEOUT       = 20000;
    localparam int SEND_TIMEOUT       = 4000;
    localparam int SEED               = 91865;
    localparam int PAYLOAD_FRAME_BITS = FRAME_HDR_BITS + PAYLOAD_BITS;
    localparam logic [ROWS-1:0] STRAY_ROWS = 5'b11010;

    logic                    clk;
    logic                    arst_n;
    logic                    tx_send;
    logic [PAYLOAD_BITS-1:0] tx_data;
    logic                    ready;
    logic                    sclk;
    logic                    mosi;
    logic                    cs_n;
    logic                    miso;

    // Stimulus table
    logic [PAYLOAD_BITS-1:0] row_payload [ROWS];
    logic                    row_stray   [ROWS];
    logic [15:0]             row_ptr     [ROWS];

    logic [15:0] exp_addr [$];
    logic [7:0]  exp_ctrl [$];
    logic [7:0]  exp_data [$];

    w5500_udp_tx dut0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .tx_send (tx_send),
        .tx_data (tx_data),
        .ready   (ready),
        .sclk    (sclk),
        .mosi    (mosi),
        .cs_n    (cs_n),
        .miso    (miso)
    );

    w5500_spi_model model0 (
        .sclk (sclk),
        .mosi (mosi),
        .cs_n (cs_n),
        .miso (miso)
    );

    bind spi_frame_engine spi_frame_engine_assertions sva0 (
        .clk    (clk),
        .arst_n (arst_n),
        .sclk   (sclk),
        .mosi   (mosi),
        .cs_n   (cs_n)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_frame(input int idx, input int len, input logic [15:0] addr,
                               input logic [7:0] ctrl, input logic [63:0] data,
                               input logic with_data);
        assert (idx < model0.frame_count) else begin
            $display("Frame %0d never appeared on the SPI bus", idx);
            abort_run();
        end
        check_value($sformatf("frame %0d length", idx), model0.log_len[idx], len);
        check_value($sformatf("frame %0d addr", idx), model0.log_addr[idx], addr);
        check_value($sformatf("frame %0d ctrl", idx), model0.log_ctrl[idx], ctrl);
        if (with_data) begin
            check_value($sformatf("frame %0d data", idx), model0.log_data[idx], data);
        end
    endtask

    // Wide values go one byte per frame, MSB at the base address
    task automatic push_bytes(input logic [15:0] base, input logic [7:0] ctrl,
                              input logic [47:0] value, input int nbytes);
        for (int i = 0; i < nbytes; i++) begin
            exp_addr.push_back(base + 16'(i));
            exp_ctrl.push_back(ctrl);
            exp_data.push_back(8'(value >> (8 * (nbytes - 1 - i))));
        end
    endtask

    task automatic push_whole(input logic [31:0] frm);
        exp_addr.push_back(frm[31:16]);
        exp_ctrl.push_back(frm[15:8]);
        exp_data.push_back(frm[7:0]);
    endtask

    task automatic build_init_expectations();
        push_whole(FRM_PHY_MODE);
        push_bytes(ADDR_MAC_BASE, CTRL_COMMON_WRITE, MAC_ADDR, 6);
        push_bytes(ADDR_IP_BASE, CTRL_COMMON_WRITE, 48'(IP_ADDR), 4);
        push_bytes(ADDR_GW_BASE, CTRL_COMMON_WRITE, 48'(GW_ADDR), 4);
        push_bytes(ADDR_MASK_BASE, CTRL_COMMON_WRITE, 48'(NET_MASK), 4);
        push_whole(FRM_S0_MODE_UDP);
        push_whole(FRM_S0_RXBUF_SIZE);
        push_whole(FRM_S0_TXBUF_SIZE);
        push_bytes(ADDR_S0_PORT, CTRL_S0_WRITE, 48'(SRC_PORT), 2);
        push_whole(FRM_S0_OPEN);
        push_bytes(ADDR_S0_DIPR, CTRL_S0_WRITE, 48'(DST_IP), 4);
        push_bytes(ADDR_S0_DPORT, CTRL_S0_WRITE, 48'(DST_PORT), 2);
    endtask

    task automatic wait_for_ready(input int limit, input string what);
        int cycles;
        cycles = 0;
        while (ready !== 1'b1 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        assert (ready === 1'b1) else begin
            $display("Timeout: ready did not rise within %0d cycles during %s", limit, what);
            abort_run();
        end
    endtask

    task automatic send_row(input int row);
        int          base;
        logic [15:0] ptr;
        base = model0.frame_count;
        ptr  = row_ptr[row];
        @(posedge clk);
        tx_send <= 1'b1;
        tx_data <= row_payload[row];
        @(posedge clk);
        tx_send <= 1'b0;
        @(negedge clk);
        check_value("ready after tx_send", ready, 1'b0);
        // A pulse while busy must be dropped
        if (row_stray[row]) begin
            @(posedge clk);
            tx_send <= 1'b1;
            tx_data <= ~row_payload[row];
            @(posedge clk);
            tx_send <= 1'b0;
        end
        wait_for_ready(SEND_TIMEOUT, $sformatf("send of row %0d", row));
        check_value("frames per send", model0.frame_count - base, 4);
        check_frame(base, PAYLOAD_FRAME_BITS, ptr, CTRL_S0_TXBUF_WRITE,
                    row_payload[row], 1'b1);
        check_frame(base + 1, CMD_FRAME_BITS, ADDR_S0_TX_WR1, CTRL_S0_WRITE,
                    64'(ptr[7:0]), 1'b1);
        check_frame(base + 2, CMD_FRAME_BITS, ADDR_S0_TX_WR0, CTRL_S0_WRITE,
                    64'(ptr[15:8]), 1'b1);
        check_frame(base + 3, CMD_FRAME_BITS, ADDR_S0_CR, CTRL_S0_WRITE,
                    64'(CMD_SEND), 1'b1);
    endtask

    initial begin
        void'($urandom(SEED));
        arst_n   = 1'b0;
        tx_send  = 1'b0;
        tx_data  = '0;
        for (int i = 0; i < ROWS; i++) begin
            row_payload[i] = {$urandom, $urandom};
            row_stray[i]   = STRAY_ROWS[i];
            row_ptr[i]     = 16'(i * PAYLOAD_BYTES);
        end
        build_init_expectations();

        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value("cs_n after reset", cs_n, 1'b1);
        check_value("ready after reset", ready, 1'b0);

        wait_for_ready(INIT_TIMEOUT, "initialisation");
        check_value("frames before ready", model0.frame_count, INIT_FRAMES + STATUS_POLLS);
        check_value("status reads", model0.status_reads, STATUS_POLLS);
        for (int i = 0; i < INIT_FRAMES; i++) begin
            check_frame(i, CMD_FRAME_BITS, exp_addr[i], exp_ctrl[i], 64'(exp_data[i]), 1'b1);
        end
        for (int i = INIT_FRAMES; i < INIT_FRAMES + STATUS_POLLS; i++) begin
            check_frame(i, CMD_FRAME_BITS, ADDR_S0_SR, CTRL_S0_READ, '0, 1'b0);
        end

        for (int row = 0; row < ROWS; row++) begin
            send_row(row);
        end

        repeat (4) @(negedge clk);
        check_value("odd length frames", model0.odd_frames, 0);
        if (dut0.spi0.sva0.fail_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("SPI pin assertions failed %0d times", dut0.spi0.sva0.fail_count);
            abort_run();
        end
    end

endmodule

//--- dv/w5500_spi_model.sv
`timescale 1ns/1ps

module w5500_spi_model (
    input  logic sclk,
    input  logic mosi,
    input  logic cs_n,
    output logic miso
);
    import w5500_regs_pkg::*;

    localparam int LOG_DEPTH        = 64;
    localparam int POLLS_BEFORE_UDP = 3;

    // Frame log, data bytes right-aligned
    logic [15:0] log_addr [LOG_DEPTH];
    logic [7:0]  log_ctrl [LOG_DEPTH];
    logic [63:0] log_data [LOG_DEPTH];
    int          log_len  [LOG_DEPTH];

    int          frame_count;
    int          status_reads;
    int          odd_frames;

    logic        in_frame;
    int          bit_cnt;
    logic [23:0] hdr;
    logic [63:0] data;
    logic        is_status;
    logic [7:0]  status_byte;

    initial begin
        miso         = 1'b0;
        frame_count  = 0;
        status_reads = 0;
        odd_frames   = 0;
        in_frame     = 1'b0;
        bit_cnt      = 0;
        is_status    = 1'b0;
        status_byte  = 8'h00;
    end

    always @(negedge cs_n) begin
        in_frame  = 1'b1;
        bit_cnt   = 0;
        hdr       = '0;
        data      = '0;
        is_status = 1'b0;
    end

    // Header first, everything after it counts as data
    always @(posedge sclk) begin
        if (!cs_n) begin
            if (bit_cnt < 24) begin
                hdr = {hdr[22:0], mosi};
            end else begin
                data = {data[62:0], mosi};
            end
            bit_cnt++;
            if (bit_cnt == 24) begin
                is_status   = (hdr[23:8] == ADDR_S0_SR) && (hdr[7:0] == CTRL_S0_READ);
                status_byte = (status_reads < POLLS_BEFORE_UDP) ? 8'h00 : STAT_SOCK_UDP;
            end
        end
    end

    // Status byte goes out MSB first, each bit set up while SCLK is low
    always @(negedge sclk) begin
        if (!cs_n && is_status && bit_cnt >= 24 && bit_cnt < 32) begin
            miso = status_byte[31 - bit_cnt];
        end else begin
            miso = 1'b0;
        end
    end

    always @(posedge cs_n) begin
        if (in_frame) begin
            in_frame = 1'b0;
            if (frame_count < LOG_DEPTH) begin
                log_addr[frame_count] = hdr[23:8];
                log_ctrl[frame_count] = hdr[7:0];
                log_data[frame_count] = data;
                log_len[frame_count]  = bit_cnt;
            end
            if (bit_cnt % 8 != 0) begin
                odd_frames++;
            end
            if (is_status) begin
                status_reads++;
            end
            frame_count++;
        end
    end

endmodule

//--- rtl/init_rom.sv
`timescale 1ns/1ps

module init_rom (
    input  logic [w5500_regs_pkg::INIT_STEP_W-1:0]    step,
    output logic [w5500_regs_pkg::CMD_FRAME_BITS-1:0] cmd
);
    import w5500_regs_pkg::*;
    import link_cfg_pkg::*;

    function automatic logic [CMD_FRAME_BITS-1:0] wr(input logic [15:0] addr,
                                                      input logic [7:0]  ctrl,
                                                      input logic [7:0]  data);
        return {addr, ctrl, data};
    endfunction

    // One register byte per frame, wide values go MSB first
    always_comb begin
        case (step)
            5'd0:  cmd = FRM_PHY_MODE;
            5'd1:  cmd = wr(ADDR_MAC_BASE,          CTRL_COMMON_WRITE, MAC_ADDR[47:40]);
            5'd2:  cmd = wr(ADDR_MAC_BASE + 16'd1,  CTRL_COMMON_WRITE, MAC_ADDR[39:32]);
            5'd3:  cmd = wr(ADDR_MAC_BASE + 16'd2,  CTRL_COMMON_WRITE, MAC_ADDR[31:24]);
            5'd4:  cmd = wr(ADDR_MAC_BASE + 16'd3,  CTRL_COMMON_WRITE, MAC_ADDR[23:16]);
            5'd5:  cmd = wr(ADDR_MAC_BASE + 16'd4,  CTRL_COMMON_WRITE, MAC_ADDR[15:8]);
            5'd6:  cmd = wr(ADDR_MAC_BASE + 16'd5,  CTRL_COMMON_WRITE, MAC_ADDR[7:0]);
            5'd7:  cmd = wr(ADDR_IP_BASE,           CTRL_COMMON_WRITE, IP_ADDR[31:24]);
            5'd8:  cmd = wr(ADDR_IP_BASE + 16'd1,   CTRL_COMMON_WRITE, IP_ADDR[23:16]);
            5'd9:  cmd = wr(ADDR_IP_BASE + 16'd2,   CTRL_COMMON_WRITE, IP_ADDR[15:8]);
            5'd10: cmd = wr(ADDR_IP_BASE + 16'd3,   CTRL_COMMON_WRITE, IP_ADDR[7:0]);
            5'd11: cmd = wr(ADDR_GW_BASE,           CTRL_COMMON_WRITE, GW_ADDR[31:24]);
            5'd12: cmd = wr(ADDR_GW_BASE + 16'd1,   CTRL_COMMON_WRITE, GW_ADDR[23:16]);
            5'd13: cmd = wr(ADDR_GW_BASE + 16'd2,   CTRL_COMMON_WRITE, GW_ADDR[15:8]);
            5'd14: cmd = wr(ADDR_GW_BASE + 16'd3,   CTRL_COMMON_WRITE, GW_ADDR[7:0]);
            5'd15: cmd = wr(ADDR_MASK_BASE,         CTRL_COMMON_WRITE, NET_MASK[31:24]);
            5'd16: cmd = wr(ADDR_MASK_BASE + 16'd1, CTRL_COMMON_WRITE, NET_MASK[23:16]);
            5'd17: cmd = wr(ADDR_MASK_BASE + 16'd2, CTRL_COMMON_WRITE, NET_MASK[15:8]);
            5'd18: cmd = wr(ADDR_MASK_BASE + 16'd3, CTRL_COMMON_WRITE, NET_MASK[7:0]);
            5'd19: cmd = FRM_S0_MODE_UDP;
            5'd20: cmd = FRM_S0_RXBUF_SIZE;
            5'd21: cmd = FRM_S0_TXBUF_SIZE;
            5'd22: cmd = wr(ADDR_S0_PORT,           CTRL_S0_WRITE, SRC_PORT[15:8]);
            5'd23: cmd = wr(ADDR_S0_PORT + 16'd1,   CTRL_S0_WRITE, SRC_PORT[7:0]);
            // Socket has to be open before the destination sticks
            5'd24: cmd = FRM_S0_OPEN;
            5'd25: cmd = wr(ADDR_S0_DIPR,           CTRL_S0_WRITE, DST_IP[31:24]);
            5'd26: cmd = wr(ADDR_S0_DIPR + 16'd1,   CTRL_S0_WRITE, DST_IP[23:16]);
            5'd27: cmd = wr(ADDR_S0_DIPR + 16'd2,   CTRL_S0_WRITE, DST_IP[15:8]);
            5'd28: cmd = wr(ADDR_S0_DIPR + 16'd3,   CTRL_S0_WRITE, DST_IP[7:0]);
            5'd29: cmd = wr(ADDR_S0_DPORT,          CTRL_S0_WRITE, DST_PORT[15:8]);
            5'd30: cmd = wr(ADDR_S0_DPORT + 16'd1,  CTRL_S0_WRITE, DST_PORT[7:0]);
            // Step 31, status read with a dummy data byte
            default: cmd = wr(ADDR_S0_SR, CTRL_S0_READ, 8'h00);
        endcase
    end

endmodule

//--- rtl/link_cfg_pkg.sv
package link_cfg_pkg;

    // Local node
    localparam logic [47:0] MAC_ADDR = 48'hAA_AF_FA_CC_E3_1C;
    localparam logic [31:0] IP_ADDR  = {8'd192, 8'd168, 8'd10, 8'd194};
    localparam logic [31:0] GW_ADDR  = {8'd192, 8'd168, 8'd10, 8'd1};
    localparam logic [31:0] NET_MASK = {8'd255, 8'd255, 8'd255, 8'd0};
    localparam logic [15:0] SRC_PORT = 16'd2390;

    // Fixed destination of every datagram
    localparam logic [31:0] DST_IP   = {8'd192, 8'd168, 8'd10, 8'd20};
    localparam logic [15:0] DST_PORT = 16'd5000;

    localparam int PAYLOAD_BITS  = 64;
    localparam int PAYLOAD_BYTES = PAYLOAD_BITS / 8;

    // Longest frame is the payload write with its header
    localparam int MAX_FRAME_BITS = PAYLOAD_BITS + w5500_regs_pkg::FRAME_HDR_BITS;
    localparam int FRAME_LEN_W    = $clog2(MAX_FRAME_BITS + 1);

    // clk cycles per SCLK half period
    localparam int SCLK_HALF_PERIOD = 4;
    localparam int SCLK_PACE_W      = $clog2(SCLK_HALF_PERIOD);

endpackage

//--- rtl/spi_frame_engine.sv
`timescale 1ns/1ps

module spi_frame_engine (
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  logic                                     start,
    input  logic [link_cfg_pkg::MAX_FRAME_BITS-1:0]  frame,
    input  logic [link_cfg_pkg::FRAME_LEN_W-1:0]     frame_bits,
    output logic                                     frame_done,
    output logic [7:0]                               rx_byte,
    output logic                                     sclk,
    output logic                                     mosi,
    output logic                                     cs_n,
    input  logic                                     miso
);
    import link_cfg_pkg::*;

    typedef enum logic [1:0] {
        E_IDLE,
        E_SETUP,
        E_SHIFT,
        E_DONE
    } eng_state_t;

    eng_state_t                 state;
    logic [MAX_FRAME_BITS-1:0]  shift_q;
    logic [FRAME_LEN_W-1:0]     bits_left;
    logic [SCLK_PACE_W-1:0]     pace;
    logic                       pace_end;
    logic                       sclk_rise;
    logic                       sclk_fall;

    assign pace_end  = (pace == SCLK_PACE_W'(SCLK_HALF_PERIOD - 1));
    assign sclk_rise = (state == E_SHIFT) && pace_end && !sclk;
    assign sclk_fall = (state == E_SHIFT) && pace_end && sclk;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= E_IDLE;
            cs_n       <= 1'b1;
            sclk       <= 1'b0;
            mosi       <= 1'b0;
            bits_left  <= '0;
            pace       <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            case (state)
                E_IDLE: begin
                    if (start) begin
                        cs_n      <= 1'b0;
                        bits_left <= frame_bits;
                        state     <= E_SETUP;
                    end
                end
                // One cycle of cs_n setup, then the first bit goes out
                E_SETUP: begin
                    mosi  <= shift_q[MAX_FRAME_BITS-1];
                    pace  <= '0;
                    state <= E_SHIFT;
                end
                E_SHIFT: begin
                    if (pace_end) begin
                        pace <= '0;
                        sclk <= ~sclk;
                        if (sclk_fall) begin
                            if (bits_left == FRAME_LEN_W'(1)) begin
                                cs_n  <= 1'b1;
                                mosi  <= 1'b0;
                                state <= E_DONE;
                            end else begin
                                bits_left <= bits_left - FRAME_LEN_W'(1);
                                mosi      <= shift_q[MAX_FRAME_BITS-2];
                            end
                        end
                    end else begin
                        pace <= pace + SCLK_PACE_W'(1);
                    end
                end
                default: begin
                    frame_done <= 1'b1;
                    state      <= E_IDLE;
                end
            endcase
        end
    end

    // Payload path, MOSI data leaves from the top and MISO collects at the bottom
    always_ff @(posedge clk) begin
        if (state == E_IDLE && start) begin
            shift_q <= frame;
        end else if (sclk_fall) begin
            shift_q <= shift_q << 1;
        end
        if (sclk_rise) begin
            rx_byte <= {rx_byte[6:0], miso};
        end
    end

endmodule

//--- rtl/w5500_regs_pkg.sv
package w5500_regs_pkg;

    // Every SPI frame starts with a 16-bit address and a control byte
    localparam int FRAME_HDR_BITS = 24;
    localparam int CMD_FRAME_BITS = 32;

    // Control byte: block select, read/write bit, variable length mode
    localparam logic [7:0] CTRL_COMMON_WRITE   = 8'h04;
    localparam logic [7:0] CTRL_S0_WRITE       = 8'h0C;
    localparam logic [7:0] CTRL_S0_READ        = 8'h08;
    localparam logic [7:0] CTRL_S0_TXBUF_WRITE = 8'h14;

    // Common register block
    localparam logic [15:0] ADDR_GW_BASE   = 16'h0001;
    localparam logic [15:0] ADDR_MASK_BASE = 16'h0005;
    localparam logic [15:0] ADDR_MAC_BASE  = 16'h0009;
    localparam logic [15:0] ADDR_IP_BASE   = 16'h000F;
    localparam logic [15:0] ADDR_PHYCFGR   = 16'h002E;

    // Socket 0 register block
    localparam logic [15:0] ADDR_S0_MR         = 16'h0000;
    localparam logic [15:0] ADDR_S0_CR         = 16'h0001;
    localparam logic [15:0] ADDR_S0_SR         = 16'h0003;
    localparam logic [15:0] ADDR_S0_PORT       = 16'h0004;
    localparam logic [15:0] ADDR_S0_DIPR       = 16'h000C;
    localparam logic [15:0] ADDR_S0_DPORT      = 16'h0010;
    localparam logic [15:0] ADDR_S0_RXBUF_SIZE = 16'h001E;
    localparam logic [15:0] ADDR_S0_TXBUF_SIZE = 16'h001F;
    localparam logic [15:0] ADDR_S0_TX_WR0     = 16'h0024;
    localparam logic [15:0] ADDR_S0_TX_WR1     = 16'h0025;

    localparam logic [7:0] CMD_OPEN      = 8'h01;
    localparam logic [7:0] CMD_SEND      = 8'h20;
    localparam logic [7:0] STAT_SOCK_UDP = 8'h22;

    // 100BT full duplex with auto-negotiation off, PHY held out of reset
    localparam logic [31:0] FRM_PHY_MODE = {ADDR_PHYCFGR, CTRL_COMMON_WRITE, 8'hD8};

    localparam logic [31:0] FRM_S0_MODE_UDP   = {ADDR_S0_MR, CTRL_S0_WRITE, 8'h02};
    // 16 KB per direction, all of the chip's buffer goes to socket 0
    localparam logic [31:0] FRM_S0_RXBUF_SIZE = {ADDR_S0_RXBUF_SIZE, CTRL_S0_WRITE, 8'd16};
    localparam logic [31:0] FRM_S0_TXBUF_SIZE = {ADDR_S0_TXBUF_SIZE, CTRL_S0_WRITE, 8'd16};
    localparam logic [31:0] FRM_S0_OPEN       = {ADDR_S0_CR, CTRL_S0_WRITE, CMD_OPEN};

    localparam int INIT_STEPS  = 32;
    localparam int INIT_STEP_W = 5;

endpackage

//--- rtl/w5500_sequencer.sv
`timescale 1ns/1ps

module w5500_sequencer (
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  logic                                     tx_send,
    input  logic [link_cfg_pkg::PAYLOAD_BITS-1:0]    tx_data,
    output logic                                     ready,
    output logic                                     start,
    output logic [link_cfg_pkg::MAX_FRAME_BITS-1:0]  frame,
    output logic [link_cfg_pkg::FRAME_LEN_W-1:0]     frame_bits,
    input  logic                                     frame_done,
    input  logic [7:0]                               rx_byte
);
    import w5500_regs_pkg::*;
    import link_cfg_pkg::*;

    typedef enum logic [2:0] {
        S_INIT,
        S_IDLE,
        S_TX_DATA,
        S_TX_WR1,
        S_TX_WR0,
        S_TX_SEND
    } seq_state_t;

    seq_state_t                 state;
    logic [INIT_STEP_W-1:0]     step;
    logic [CMD_FRAME_BITS-1:0]  init_cmd;
    logic [CMD_FRAME_BITS-1:0]  short_cmd;
    logic [PAYLOAD_BITS-1:0]    payload;
    logic [15:0]                tx_ptr;
    logic                       in_flight;
    logic                       last_step;

    init_rom init_rom0 (
        .step (step),
        .cmd  (init_cmd)
    );

    assign ready     = (state == S_IDLE);
    assign last_step = (step == INIT_STEP_W'(INIT_STEPS - 1));

    // Short frames sit at the top of the frame bus
    always_comb begin
        case (state)
            S_TX_WR1:  short_cmd = {ADDR_S0_TX_WR1, CTRL_S0_WRITE, tx_ptr[7:0]};
            S_TX_WR0:  short_cmd = {ADDR_S0_TX_WR0, CTRL_S0_WRITE, tx_ptr[15:8]};
            S_TX_SEND: short_cmd = {ADDR_S0_CR, CTRL_S0_WRITE, CMD_SEND};
            default:   short_cmd = init_cmd;
        endcase
        if (state == S_TX_DATA) begin
            frame      = {tx_ptr, CTRL_S0_TXBUF_WRITE, payload};
            frame_bits = FRAME_LEN_W'(MAX_FRAME_BITS);
        end else begin
            frame      = {short_cmd, {(MAX_FRAME_BITS - CMD_FRAME_BITS){1'b0}}};
            frame_bits = FRAME_LEN_W'(CMD_FRAME_BITS);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= S_INIT;
            step      <= '0;
            tx_ptr    <= '0;
            in_flight <= 1'b0;
            start     <= 1'b0;
        end else begin
            start <= 1'b0;
            // Every state except idle owns exactly one frame
            if (state != S_IDLE && !in_flight) begin
                start     <= 1'b1;
                in_flight <= 1'b1;
            end
            if (frame_done) begin
                in_flight <= 1'b0;
                case (state)
                    S_INIT: begin
                        // Last step is the status read, repeated until UDP mode shows
                        if (!last_step) begin
                            step <= step + INIT_STEP_W'(1);
                        end else if (rx_byte == STAT_SOCK_UDP) begin
                            state <= S_IDLE;
                        end
                    end
                    S_TX_DATA: state <= S_TX_WR1;
                    S_TX_WR1:  state <= S_TX_WR0;
                    S_TX_WR0:  state <= S_TX_SEND;
                    S_TX_SEND: begin
                        state  <= S_IDLE;
                        tx_ptr <= tx_ptr + 16'(PAYLOAD_BYTES);
                    end
                    default: state <= S_IDLE;
                endcase
            end
            if (state == S_IDLE && tx_send) begin
                state <= S_TX_DATA;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && tx_send) begin
            payload <= tx_data;
        end
    end

endmodule

//--- rtl/w5500_udp_tx.sv
`timescale 1ns/1ps

module w5500_udp_tx (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic                                   tx_send,
    input  logic [link_cfg_pkg::PAYLOAD_BITS-1:0]  tx_data,
    output logic                                   ready,
    output logic                                   sclk,
    output logic                                   mosi,
    output logic                                   cs_n,
    input  logic                                   miso
);
    import link_cfg_pkg::*;

    logic                       start;
    logic [MAX_FRAME_BITS-1:0]  frame;
    logic [FRAME_LEN_W-1:0]     frame_bits;
    logic                       frame_done;
    logic [7:0]                 rx_byte;

    w5500_sequencer seq0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .tx_send    (tx_send),
        .tx_data    (tx_data),
        .ready      (ready),
        .start      (start),
        .frame      (frame),
        .frame_bits (frame_bits),
        .frame_done (frame_done),
        .rx_byte    (rx_byte)
    );

    spi_frame_engine spi0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .frame      (frame),
        .frame_bits (frame_bits),
        .frame_done (frame_done),
        .rx_byte    (rx_byte),
        .sclk       (sclk),
        .mosi       (mosi),
        .cs_n       (cs_n),
        .miso       (miso)
    );

endmodule

//--- w5500_udp_tx.f
rtl/w5500_regs_pkg.sv
rtl/link_cfg_pkg.sv
rtl/init_rom.sv
rtl/spi_frame_engine.sv
rtl/w5500_sequencer.sv
rtl/w5500_udp_tx.sv
dv/spi_frame_engine_assertions.sv
dv/w5500_spi_model.sv
dv/tb_w5500_udp_tx.sv
